// File: common/mem_route_pkg.sv
package mem_route_pkg;

    // Bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int strb_w = 4;

    // Path order tracking
    localparam int order_depth = 8;
    localparam int order_ptr_w = 3;

    // Per-master limit on transactions in flight
    localparam int max_outstanding = 4;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Requester side
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic [strb_w-1:0] strb;
        logic              write;
        logic              cached;
    } mem_req_t;

    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              err;
    } mem_rsp_t;

    // AR and AW share one payload layout
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [2:0]        prot;
    } axil_addr_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
    } axil_wdata_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
    } axil_rdata_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_bresp_t;

endpackage

// File: hw/order_fifo.sv
`timescale 1ns/1ps

module order_fifo
    import mem_route_pkg::*;
(
    input  logic aclk,
    input  logic aresetn,
    input  logic push,
    input  logic tag_in,
    input  logic pop,
    output logic head_tag,
    output logic empty,
    output logic full
);

    logic [order_depth-1:0] tags;
    logic [order_ptr_w-1:0] wr_ptr;
    logic [order_ptr_w-1:0] rd_ptr;
    logic [order_ptr_w:0]   count;
    logic                   push_en;
    logic                   pop_en;

    assign empty = (count == '0);
    assign full  = (count == (order_ptr_w + 1)'(order_depth));

    // Overflow and underflow are ignored
    assign push_en = push && !full;
    assign pop_en  = pop && !empty;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push_en) begin
            tags[wr_ptr] <= tag_in;
        end
    end

    // Path of the oldest outstanding request
    assign head_tag = tags[rd_ptr];

endmodule

// File: hw/mem_router.sv
`timescale 1ns/1ps

module mem_router
    import mem_route_pkg::*;
(
    input  logic     aclk,
    input  logic     aresetn,

    input  mem_req_t req,
    input  logic     req_valid,
    output logic     req_ready,
    output mem_rsp_t rsp,
    output logic     rsp_valid,

    output mem_req_t cached_req,
    output logic     cached_valid,
    input  logic     cached_ready,
    input  mem_rsp_t cached_rsp,
    input  logic     cached_rsp_valid,

    output mem_req_t uncached_req,
    output logic     uncached_valid,
    input  logic     uncached_ready,
    input  mem_rsp_t uncached_rsp,
    input  logic     uncached_rsp_valid
);

    logic head_tag;
    logic fifo_empty;
    logic fifo_full;
    logic path_ok;
    logic target_ready;
    logic accept;

    // A new request may only follow requests on the same path
    assign path_ok = !fifo_full && (fifo_empty || (head_tag == req.cached));

    assign target_ready = req.cached ? cached_ready : uncached_ready;

    assign req_ready = path_ok && target_ready;
    assign accept    = req_valid && req_ready;

    // Both masters see the payload, valid only goes one way
    assign cached_req     = req;
    assign uncached_req   = req;
    assign cached_valid   = req_valid && path_ok && req.cached;
    assign uncached_valid = req_valid && path_ok && !req.cached;

    // Only one path has traffic at a time, so at most one returns
    assign rsp_valid = cached_rsp_valid || uncached_rsp_valid;
    assign rsp       = head_tag ? cached_rsp : uncached_rsp;

    order_fifo u_order_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (accept),
        .tag_in   (req.cached),
        .pop      (rsp_valid),
        .head_tag (head_tag),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

endmodule

// File: axil_master/axil_master.sv
`timescale 1ns/1ps

module axil_master
    import mem_route_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,

    input  mem_req_t    req,
    input  logic        req_valid,
    output logic        req_ready,
    output mem_rsp_t    rsp,
    output logic        rsp_valid,

    output axil_addr_t  ar,
    output logic        arvalid,
    input  logic        arready,

    input  axil_rdata_t r,
    input  logic        rvalid,
    output logic        rready,

    output axil_addr_t  aw,
    output logic        awvalid,
    input  logic        awready,

    output axil_wdata_t w,
    output logic        wvalid,
    input  logic        wready,

    input  axil_bresp_t b,
    input  logic        bvalid,
    output logic        bready
);

    logic [$clog2(max_outstanding + 1)-1:0] inflight;
    logic                                   kind_wr;
    logic                                   active;
    logic                                   chan_free;
    logic                                   kind_ok;
    logic                                   accept;
    logic                                   r_done;
    logic                                   b_done;
    logic                                   done;

    // Held low until the first clock after reset
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            active <= 1'b0;
        end else begin
            active <= 1'b1;
        end
    end

    assign chan_free = !arvalid && !awvalid && !wvalid;
    assign kind_ok   = (inflight == '0) || (kind_wr == req.write);
    assign req_ready = active && chan_free && kind_ok && (inflight < max_outstanding);
    assign accept    = req_valid && req_ready;

    assign rready = (inflight != '0) && !kind_wr;
    assign bready = (inflight != '0) && kind_wr;
    assign r_done = rvalid && rready;
    assign b_done = bvalid && bready;
    assign done   = r_done || b_done;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arvalid  <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            kind_wr  <= 1'b0;
            inflight <= '0;
        end else begin
            if (accept) begin
                kind_wr <= req.write;
                arvalid <= !req.write;
                awvalid <= req.write;
                wvalid  <= req.write;
            end else begin
                // AW and W drop on their own handshakes
                if (arvalid && arready) begin
                    arvalid <= 1'b0;
                end
                if (awvalid && awready) begin
                    awvalid <= 1'b0;
                end
                if (wvalid && wready) begin
                    wvalid <= 1'b0;
                end
            end
            case ({accept, done})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    // Channel payloads
    always_ff @(posedge aclk) begin
        if (accept) begin
            ar.addr <= req.addr;
            ar.prot <= 3'b000;
            aw.addr <= req.addr;
            aw.prot <= 3'b000;
            w.data  <= req.wdata;
            w.strb  <= req.strb;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= done;
        end
    end

    always_ff @(posedge aclk) begin
        if (r_done) begin
            rsp.rdata <= r.data;
            rsp.err   <= (r.resp != resp_okay);
        end else if (b_done) begin
            rsp.rdata <= '0;
            rsp.err   <= (b.resp != resp_okay);
        end
    end

endmodule

// File: hw/mem_router_top.sv
`timescale 1ns/1ps

module mem_router_top
    import mem_route_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,

    input  mem_req_t    req,
    input  logic        req_valid,
    output logic        req_ready,
    output mem_rsp_t    rsp,
    output logic        rsp_valid,

    // Cached path
    output axil_addr_t  c_ar,
    output logic        c_arvalid,
    input  logic        c_arready,
    input  axil_rdata_t c_r,
    input  logic        c_rvalid,
    output logic        c_rready,
    output axil_addr_t  c_aw,
    output logic        c_awvalid,
    input  logic        c_awready,
    output axil_wdata_t c_w,
    output logic        c_wvalid,
    input  logic        c_wready,
    input  axil_bresp_t c_b,
    input  logic        c_bvalid,
    output logic        c_bready,

    // Uncached path
    output axil_addr_t  u_ar,
    output logic        u_arvalid,
    input  logic        u_arready,
    input  axil_rdata_t u_r,
    input  logic        u_rvalid,
    output logic        u_rready,
    output axil_addr_t  u_aw,
    output logic        u_awvalid,
    input  logic        u_awready,
    output axil_wdata_t u_w,
    output logic        u_wvalid,
    input  logic        u_wready,
    input  axil_bresp_t u_b,
    input  logic        u_bvalid,
    output logic        u_bready
);

    mem_req_t cached_req;
    logic     cached_valid;
    logic     cached_ready;
    mem_rsp_t cached_rsp;
    logic     cached_rsp_valid;

    mem_req_t uncached_req;
    logic     uncached_valid;
    logic     uncached_ready;
    mem_rsp_t uncached_rsp;
    logic     uncached_rsp_valid;

    mem_router u_router (
        .aclk               (aclk),
        .aresetn            (aresetn),
        .req                (req),
        .req_valid          (req_valid),
        .req_ready          (req_ready),
        .rsp                (rsp),
        .rsp_valid          (rsp_valid),
        .cached_req         (cached_req),
        .cached_valid       (cached_valid),
        .cached_ready       (cached_ready),
        .cached_rsp         (cached_rsp),
        .cached_rsp_valid   (cached_rsp_valid),
        .uncached_req       (uncached_req),
        .uncached_valid     (uncached_valid),
        .uncached_ready     (uncached_ready),
        .uncached_rsp       (uncached_rsp),
        .uncached_rsp_valid (uncached_rsp_valid)
    );

    axil_master u_cached_master (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req       (cached_req),
        .req_valid (cached_valid),
        .req_ready (cached_ready),
        .rsp       (cached_rsp),
        .rsp_valid (cached_rsp_valid),
        .ar        (c_ar),
        .arvalid   (c_arvalid),
        .arready   (c_arready),
        .r         (c_r),
        .rvalid    (c_rvalid),
        .rready    (c_rready),
        .aw        (c_aw),
        .awvalid   (c_awvalid),
        .awready   (c_awready),
        .w         (c_w),
        .wvalid    (c_wvalid),
        .wready    (c_wready),
        .b         (c_b),
        .bvalid    (c_bvalid),
        .bready    (c_bready)
    );

    axil_master u_uncached_master (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req       (uncached_req),
        .req_valid (uncached_valid),
        .req_ready (uncached_ready),
        .rsp       (uncached_rsp),
        .rsp_valid (uncached_rsp_valid),
        .ar        (u_ar),
        .arvalid   (u_arvalid),
        .arready   (u_arready),
        .r         (u_r),
        .rvalid    (u_rvalid),
        .rready    (u_rready),
        .aw        (u_aw),
        .awvalid   (u_awvalid),
        .awready   (u_awready),
        .w         (u_w),
        .wvalid    (u_wvalid),
        .wready    (u_wready),
        .b         (u_b),
        .bvalid    (u_bvalid),
        .bready    (u_bready)
    );

endmodule

// File: tb/axil_slave_model.sv
`timescale 1ns/1ps

module axil_slave_model
    import mem_route_pkg::*;
#(
    parameter bit path = 1'b0
)
(
    input  logic        aclk,
    input  logic        aresetn,
    input  axil_addr_t  ar,
    input  logic        arvalid,
    output logic        arready,
    output axil_rdata_t r,
    output logic        rvalid,
    input  logic        rready,
    input  axil_addr_t  aw,
    input  logic        awvalid,
    output logic        awready,
    input  axil_wdata_t w,
    input  logic        wvalid,
    output logic        wready,
    output axil_bresp_t b,
    output logic        bvalid,
    input  logic        bready,
    output int          path_errors
);

    logic [data_w-1:0] mem [1024];
    axil_addr_t        aw_q [$];
    axil_wdata_t       w_q [$];
    axil_rdata_t       r_q [$];
    axil_bresp_t       b_q [$];
    logic              r_fire;
    logic              b_fire;
    int                seed;

    // Upper 1 KB of the 4 KB window
    function automatic bit in_error_region(input logic [addr_w-1:0] addr);
        return addr[11:10] == 2'b11;
    endfunction

    // Bit 12 of every test address names the path it was issued on
    task automatic check_path(input logic [addr_w-1:0] addr);
        if (addr[12] != path) begin
            path_errors++;
            $display("Slave on path %0d received address %h from the other path", path, addr);
        end
    endtask

    always @(posedge aclk) begin
        axil_rdata_t rd;
        axil_bresp_t br;
        axil_addr_t  a;
        axil_wdata_t d;
        int          i;
        if (!aresetn) begin
            aw_q.delete();
            w_q.delete();
            r_q.delete();
            b_q.delete();
            path_errors = 0;
            r_fire      = 1'b0;
            b_fire      = 1'b0;
            for (i = 0; i < 1024; i++) begin
                mem[i] = {path ? 16'hc0de : 16'h0dd5, 6'd0, i[9:0]};
            end
        end else begin
            r_fire = rvalid && rready;
            b_fire = bvalid && bready;
            if (r_fire) begin
                void'(r_q.pop_front());
            end
            if (b_fire) begin
                void'(b_q.pop_front());
            end
            // Read data is taken when the address arrives
            if (arvalid && arready) begin
                check_path(ar.addr);
                rd.resp = in_error_region(ar.addr) ? resp_slverr : resp_okay;
                rd.data = in_error_region(ar.addr) ? '0 : mem[ar.addr[11:2]];
                r_q.push_back(rd);
            end
            if (awvalid && awready) begin
                check_path(aw.addr);
                aw_q.push_back(aw);
            end
            if (wvalid && wready) begin
                w_q.push_back(w);
            end
            while (aw_q.size() != 0 && w_q.size() != 0) begin
                a = aw_q.pop_front();
                d = w_q.pop_front();
                if (!in_error_region(a.addr)) begin
                    for (i = 0; i < strb_w; i++) begin
                        if (d.strb[i]) begin
                            mem[a.addr[11:2]][8*i +: 8] = d.data[8*i +: 8];
                        end
                    end
                end
                br.resp = in_error_region(a.addr) ? resp_slverr : resp_okay;
                b_q.push_back(br);
            end
        end
    end

    initial begin
        seed    = 32'h0bea0dca ^ (path ? 32'h5 : 32'ha);
        arready = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        rvalid  = 1'b0;
        bvalid  = 1'b0;
        r       = '0;
        b       = '0;
        forever begin
            @(negedge aclk);
            arready = (($random(seed) & 3) != 0);
            awready = (($random(seed) & 3) != 0);
            wready  = (($random(seed) & 3) != 0);
            // A raised valid stays up until its handshake
            if (!rvalid || r_fire) begin
                rvalid = (r_q.size() != 0) && (($random(seed) & 1) == 1);
                if (rvalid) begin
                    r = r_q[0];
                end
            end
            if (!bvalid || b_fire) begin
                bvalid = (b_q.size() != 0) && (($random(seed) & 1) == 1);
                if (bvalid) begin
                    b = b_q[0];
                end
            end
        end
    end

endmodule

// File: tb/mem_router_assert.sv
`timescale 1ns/1ps

module mem_router_assert (
    input logic aclk,
    input logic aresetn,
    input logic req_valid,
    input logic req_ready,
    input logic rsp_valid,
    input logic c_arvalid,
    input logic c_arready,
    input logic u_arvalid,
    input logic u_arready,
    input logic cached_rsp_valid,
    input logic uncached_rsp_valid
);

    int pending;
    // Count of failed assertions
    int failures;

    // Responses still owed to the requester
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pending <= 0;
        end else begin
            pending <= pending + int'(req_valid && req_ready) - int'(rsp_valid);
        end
    end

    ar_hold_c: assert property (@(posedge aclk) disable iff (!aresetn)
        c_arvalid && !c_arready |=> c_arvalid)
        else begin
            failures++;
            $error("Cached AR valid dropped before its ready");
        end

    ar_hold_u: assert property (@(posedge aclk) disable iff (!aresetn)
        u_arvalid && !u_arready |=> u_arvalid)
        else begin
            failures++;
            $error("Uncached AR valid dropped before its ready");
        end

    one_rsp_path: assert property (@(posedge aclk) disable iff (!aresetn)
        !(cached_rsp_valid && uncached_rsp_valid))
        else begin
            failures++;
            $error("Both masters returned a response in one cycle");
        end

    rsp_owed: assert property (@(posedge aclk) disable iff (!aresetn)
        rsp_valid |-> pending > 0)
        else begin
            failures++;
            $error("Response with no request outstanding");
        end

endmodule

bind mem_router_top mem_router_assert u_assert (.*);

// File: tb/tb_mem_router.sv
`timescale 1ns/1ps

module tb_mem_router
    import mem_route_pkg::*;
();

    localparam int num_requests = 400;
    localparam int wait_limit   = 500;

    logic        aclk;
    logic        aresetn;
    mem_req_t    req;
    logic        req_valid;
    logic        req_ready;
    mem_rsp_t    rsp;
    logic        rsp_valid;

    axil_addr_t  c_ar, c_aw, u_ar, u_aw;
    axil_wdata_t c_w, u_w;
    axil_rdata_t c_r, u_r;
    axil_bresp_t c_b, u_b;
    logic        c_arvalid, c_arready, c_rvalid, c_rready, c_awvalid, c_awready;
    logic        c_wvalid, c_wready, c_bvalid, c_bready;
    logic        u_arvalid, u_arready, u_rvalid, u_rready, u_awvalid, u_awready;
    logic        u_wvalid, u_wready, u_bvalid, u_bready;
    int          c_path_errors;
    int          u_path_errors;

    int                seed;
    int                checks;
    int                errors;
    int                timeouts;
    int                outstanding [2];
    logic [data_w-1:0] model_mem [2][1024];
    mem_rsp_t          exp_q [$];
    logic              path_q [$];

    mem_router_top u_dut (.*);

    axil_slave_model #(.path(1'b1)) u_cached_mem (
        .aclk (aclk), .aresetn (aresetn),
        .ar (c_ar), .arvalid (c_arvalid), .arready (c_arready),
        .r (c_r), .rvalid (c_rvalid), .rready (c_rready),
        .aw (c_aw), .awvalid (c_awvalid), .awready (c_awready),
        .w (c_w), .wvalid (c_wvalid), .wready (c_wready),
        .b (c_b), .bvalid (c_bvalid), .bready (c_bready),
        .path_errors (c_path_errors)
    );

    axil_slave_model #(.path(1'b0)) u_uncached_mem (
        .aclk (aclk), .aresetn (aresetn),
        .ar (u_ar), .arvalid (u_arvalid), .arready (u_arready),
        .r (u_r), .rvalid (u_rvalid), .rready (u_rready),
        .aw (u_aw), .awvalid (u_awvalid), .awready (u_awready),
        .w (u_w), .wvalid (u_wvalid), .wready (u_wready),
        .b (u_b), .bvalid (u_bvalid), .bready (u_bready),
        .path_errors (u_path_errors)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        int assert_failures;
        assert_failures = u_dut.u_assert.failures;
        $display("checks %0d, errors %0d, path errors %0d, assertion failures %0d, timeouts %0d",
                 checks, errors, c_path_errors + u_path_errors, assert_failures, timeouts);
        if (errors == 0 && timeouts == 0 && c_path_errors == 0 && u_path_errors == 0 &&
            assert_failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // Slave memory model updated at acceptance
    function automatic mem_rsp_t apply_request(input mem_req_t r);
        mem_rsp_t res;
        int       i;
        res.err   = (r.addr[11:10] == 2'b11);
        res.rdata = '0;
        if (!res.err && r.write) begin
            for (i = 0; i < strb_w; i++) begin
                if (r.strb[i]) begin
                    model_mem[r.cached][r.addr[11:2]][8*i +: 8] = r.wdata[8*i +: 8];
                end
            end
        end else if (!res.err) begin
            res.rdata = model_mem[r.cached][r.addr[11:2]];
        end
        return res;
    endfunction

    // Few word addresses so reads hit earlier writes
    // Bit 12 carries the path
    function automatic mem_req_t make_request(input logic path);
        mem_req_t   r;
        logic [1:0] region;
        region   = (($random(seed) & 7) == 0) ? 2'b11 : 2'b00;
        r.addr   = {19'd0, path, region, 4'd0, 4'($random(seed)), 2'b00};
        r.wdata  = $random(seed);
        r.strb   = 4'($random(seed));
        r.write  = (($random(seed) & 1) == 1);
        r.cached = path;
        return r;
    endfunction

    task automatic send_request(input mem_req_t r);
        int waited;
        req       = r;
        req_valid = 1'b1;
        waited    = 0;
        @(posedge aclk);
        while (!req_ready && waited < wait_limit) begin
            waited++;
            @(posedge aclk);
        end
        if (!req_ready) begin
            timeouts++;
            $display("Timeout: request to address %h was never accepted", r.addr);
        end
        @(negedge aclk);
        req_valid = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < wait_limit) begin
            waited++;
            @(negedge aclk);
        end
        if (exp_q.size() != 0) begin
            timeouts++;
            $display("Timeout: %0d responses never arrived", exp_q.size());
        end
    endtask

    // Scoreboard sampled on the rising edge
    always @(posedge aclk) begin
        mem_rsp_t expected;
        logic     exp_path;
        if (aresetn) begin
            if (req_ready) begin
                check_value("req_ready_path", 0, outstanding[!req.cached]);
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(apply_request(req));
                path_q.push_back(req.cached);
                outstanding[req.cached]++;
            end
            if (rsp_valid && exp_q.size() == 0) begin
                errors++;
                $display("A response arrived with no request outstanding");
            end else if (rsp_valid) begin
                expected = exp_q.pop_front();
                exp_path = path_q.pop_front();
                outstanding[exp_path]--;
                check_value("rsp_rdata", expected.rdata, rsp.rdata);
                check_value("rsp_err", expected.err, rsp.err);
            end
        end
    end

    initial begin
        logic path;
        int   gap;
        int   p;
        int   i;
        int   n;
        seed      = 32'h0bea0dca;
        path      = 1'b0;
        aresetn   = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        for (p = 0; p < 2; p++) begin
            for (i = 0; i < 1024; i++) begin
                model_mem[p][i] = {(p == 1) ? 16'hc0de : 16'h0dd5, 6'd0, i[9:0]};
            end
        end
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        check_value("reset_outputs", '0, {req_ready, rsp_valid, c_arvalid, c_awvalid,
                                          c_wvalid, u_arvalid, u_awvalid, u_wvalid});
        aresetn = 1'b1;
        for (n = 0; n < num_requests && timeouts == 0; n++) begin
            // Mostly runs on one path
            if (($random(seed) & 3) == 0) begin
                path = !path;
            end
            send_request(make_request(path));
            gap = $random(seed) & 3;
            repeat (gap) @(negedge aclk);
        end
        if (timeouts == 0) begin
            wait_for_drain();
        end
        finish_run();
    end

endmodule

// File: filelist.f
common/mem_route_pkg.sv
hw/order_fifo.sv
hw/mem_router.sv
axil_master/axil_master.sv
hw/mem_router_top.sv
tb/axil_slave_model.sv
tb/mem_router_assert.sv
tb/tb_mem_router.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_mem_router
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
